// File: files.f
+incdir+logic
logic/ads1292_pkg.sv
logic/spi_timing.sv
logic/spi_shift_reg.sv
logic/ads1292_fsm.sv
logic/ads1292_sensor_top.sv
sim/ads1292_assertions.sv
sim/ads1292_tb.sv

// File: Makefile
# Verilator flow for the ADS1292 controller

VERILATOR  ?= verilator
TOP        ?= ads1292_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= NO ERRORS

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(FILELIST) $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Status comes from the search for the pass line
run: build
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/ads1292_tb.sv
`default_nettype none

`include "ads1292_defines.svh"

module ads1292_tb import ads1292_pkg::*; ();

	localparam int CLK_HALF     = 2;
	localparam int FRAME_BYTES  = `ADS_FRAME_W / `ADS_BYTE_W;
	localparam int FRAME_CYCLES = 2 * `ADS_SCLK_HALF * (`ADS_FRAME_W + 2) + 16;
	// About 3.3k cycles of tests, nine byte transfers and four frame windows
	localparam int TIMEOUT_CYCLES = 20000;

	logic   clk;
	logic   arst_n;
	ctrl_t  control;
	byte_t  command;
	byte_t  reg_addr;
	byte_t  data_in;
	logic   spi_miso = 1'b0;
	logic   ads_drdy_n;
	frame_t data_out;
	byte_t  reg_data;
	logic   data_ready;
	logic   init_set;
	logic   busy;
	logic   spi_clk;
	logic   spi_mosi;
	logic   spi_cs_n;
	logic   ads_reset_n;
	logic   ads_start;

	int     err_cnt = 0;
	int     tests_run = 0;
	int     tests_passed = 0;
	int     cycle_cnt = 0;

	// Chip model state
	byte_t  mosi_q[$];     // Every byte seen on MOSI
	byte_t  miso_q[$];     // Bytes waiting to go out on MISO
	byte_t  mosi_sr = '0;
	byte_t  miso_sr = '0;
	int     mosi_bits = 0;
	int     miso_bits = 0;

	ads1292_sensor_top i_dut (
		.i_clk         (clk),
		.i_arst_n      (arst_n),
		.i_control     (control),
		.i_command     (command),
		.i_reg_addr    (reg_addr),
		.i_data_in     (data_in),
		.o_data_out    (data_out),
		.o_reg_data    (reg_data),
		.o_data_ready  (data_ready),
		.o_init_set    (init_set),
		.o_busy        (busy),
		.o_spi_clk     (spi_clk),
		.i_spi_miso    (spi_miso),
		.o_spi_mosi    (spi_mosi),
		.o_spi_cs_n    (spi_cs_n),
		.i_ads_drdy_n  (ads_drdy_n),
		.o_ads_reset_n (ads_reset_n),
		.o_ads_start   (ads_start)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// ======================================================================
	// ADS1292 SPI slave model
	// ======================================================================
	always @(negedge spi_clk) begin
		if (arst_n && !spi_cs_n) begin   // Chip samples MOSI on the falling edge
			mosi_sr = {mosi_sr[`ADS_BYTE_W-2:0], spi_mosi};
			mosi_bits++;
			if (mosi_bits == `ADS_BYTE_W) begin
				mosi_q.push_back(mosi_sr);
				mosi_bits = 0;
			end
		end
	end

	always @(posedge spi_clk) begin
		if (arst_n && !spi_cs_n) begin
			if (miso_bits == 0)
				miso_sr = (miso_q.size() > 0) ? miso_q.pop_front() : '0;   // Idle bytes are zero
			spi_miso <= miso_sr[`ADS_BYTE_W-1];
			miso_sr = {miso_sr[`ADS_BYTE_W-2:0], 1'b0};
			miso_bits = (miso_bits + 1) % `ADS_BYTE_W;
		end
	end

	// ======================================================================
	// Reporting and host helpers
	// ======================================================================
	task automatic report_mismatch(input string test, input string what,
		input frame_t exp_val, input frame_t act_val);
		$display("Error: %s: %s expected %0h, actual %0h", test, what, exp_val, act_val);
		err_cnt++;
	endtask

	task automatic note_failure(input string test, input string what);
		$display("%s: %s", test, what);
		err_cnt++;
	endtask

	task automatic finish_test(input string test, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before) begin
			tests_passed++;
			$display("PASS %s", test);
		end else begin
			$display("FAIL %s, %0d mismatches", test, err_cnt - errs_before);
		end
	endtask

	// One byte of an operation, idx counts from the mark taken before it
	task automatic expect_mosi(input string test, input int mark, input int idx,
		input byte_t exp_val);
		if (mosi_q.size() <= mark + idx)
			note_failure(test, $sformatf("chip never received byte %0d", idx));
		else if (mosi_q[mark + idx] !== exp_val)
			report_mismatch(test, $sformatf("MOSI byte %0d", idx), frame_t'(exp_val),
				frame_t'(mosi_q[mark + idx]));
	endtask

	// Raise a control level, drop it once busy rises, then wait for idle
	task automatic run_op(input ctrl_t op, input byte_t cmd, input byte_t addr,
		input byte_t dat);
		@(posedge clk);
		control  <= op;
		command  <= cmd;
		reg_addr <= addr;
		data_in  <= dat;
		@(negedge clk);
		while (busy !== 1'b1)
			@(negedge clk);
		@(posedge clk);
		control <= ctrl_t'(`ADS_CTRL_NONE);
		@(negedge clk);
		while (busy !== 1'b0)
			@(negedge clk);
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================
	task automatic check_power_up();
		int errs_before;
		int low_cycles;
		int wake_cycles;
		logic cs_seen;
		errs_before = err_cnt;
		low_cycles  = 0;
		wake_cycles = 0;
		cs_seen     = 1'b0;
		@(negedge clk);
		if (ads_reset_n !== 1'b0)
			report_mismatch("power_up", "o_ads_reset_n", frame_t'(1'b0), frame_t'(ads_reset_n));
		if (busy !== 1'b1)
			report_mismatch("power_up", "o_busy", frame_t'(1'b1), frame_t'(busy));
		while (ads_reset_n !== 1'b1) begin   // Reset pulse
			low_cycles++;
			cs_seen |= (spi_cs_n !== 1'b1);
			@(negedge clk);
		end
		while (busy !== 1'b0) begin          // Wake wait
			wake_cycles++;
			cs_seen |= (spi_cs_n !== 1'b1);
			@(negedge clk);
		end
		if (low_cycles < `ADS_RESET_CYCLES)
			note_failure("power_up", $sformatf("reset pin low for only %0d cycles", low_cycles));
		if (wake_cycles < `ADS_WAKE_CYCLES)
			note_failure("power_up", $sformatf("busy fell %0d cycles after wake", wake_cycles));
		if (cs_seen)
			note_failure("power_up", "chip select left high level during power-up");
		finish_test("power_up", errs_before);
	endtask

	task automatic send_command();
		int errs_before;
		int mark;
		byte_t op;
		errs_before = err_cnt;
		op   = byte_t'($urandom);
		mark = mosi_q.size();
		run_op(ctrl_t'(`ADS_CTRL_CMD), op, '0, '0);
		if (mosi_q.size() - mark != 1)
			report_mismatch("command", "byte count", frame_t'(1), frame_t'(mosi_q.size() - mark));
		expect_mosi("command", mark, 0, op);
		finish_test("command", errs_before);
	endtask

	task automatic write_register();
		int errs_before;
		int mark;
		byte_t addr;
		byte_t dat;
		errs_before = err_cnt;
		addr = byte_t'($urandom % 12);   // ADS1292 register map
		dat  = byte_t'($urandom);
		mark = mosi_q.size();
		run_op(ctrl_t'(`ADS_CTRL_WREG), '0, addr, dat);
		if (mosi_q.size() - mark != 3)
			report_mismatch("write_reg", "byte count", frame_t'(3), frame_t'(mosi_q.size() - mark));
		expect_mosi("write_reg", mark, 0, byte_t'(`ADS_OP_WREG) | addr);
		expect_mosi("write_reg", mark, 1, 8'h00);   // One register
		expect_mosi("write_reg", mark, 2, dat);
		finish_test("write_reg", errs_before);
	endtask

	task automatic read_register();
		int errs_before;
		int mark;
		byte_t addr;
		byte_t rd_val;
		errs_before = err_cnt;
		addr   = byte_t'($urandom % 12);
		rd_val = byte_t'($urandom);
		miso_q.push_back(8'h00);   // Opcode and count bytes
		miso_q.push_back(8'h00);
		miso_q.push_back(rd_val);
		mark = mosi_q.size();
		run_op(ctrl_t'(`ADS_CTRL_RREG), '0, addr, '0);
		if (mosi_q.size() - mark != 3)
			report_mismatch("read_reg", "byte count", frame_t'(3), frame_t'(mosi_q.size() - mark));
		expect_mosi("read_reg", mark, 0, byte_t'(`ADS_OP_RREG) | addr);
		expect_mosi("read_reg", mark, 1, 8'h00);
		if (reg_data !== rd_val)
			report_mismatch("read_reg", "o_reg_data", frame_t'(rd_val), frame_t'(reg_data));
		finish_test("read_reg", errs_before);
	endtask

	task automatic stream_frames();
		int errs_before;
		int mark;
		int i;
		int b;
		frame_t frame;
		errs_before = err_cnt;
		mark = mosi_q.size();
		run_op(ctrl_t'(`ADS_CTRL_RDATAC), '0, '0, '0);
		if (mosi_q.size() - mark != 1)
			report_mismatch("rdatac", "byte count", frame_t'(1), frame_t'(mosi_q.size() - mark));
		expect_mosi("rdatac", mark, 0, 8'h10);
		if (init_set !== 1'b1)
			report_mismatch("rdatac", "o_init_set", frame_t'(1'b1), frame_t'(init_set));
		if (ads_start !== 1'b1)
			report_mismatch("rdatac", "o_ads_start", frame_t'(1'b1), frame_t'(ads_start));
		for (i = 0; i < 3; i++) begin
			frame = frame_t'({$urandom, $urandom, $urandom});
			for (b = FRAME_BYTES - 1; b >= 0; b--)
				miso_q.push_back(frame[b*`ADS_BYTE_W +: `ADS_BYTE_W]);   // Status word first
			@(posedge clk);
			ads_drdy_n <= 1'b0;
			@(negedge clk);
			while (data_ready !== 1'b1)
				@(negedge clk);
			if (data_out !== frame)
				report_mismatch("rdatac", $sformatf("frame %0d", i), frame, data_out);
			@(posedge clk);
			ads_drdy_n <= 1'b1;
			repeat (4) @(posedge clk);   // Synchronizer sees DRDY high again
		end
		finish_test("rdatac", errs_before);
	endtask

	task automatic stop_stream();
		int errs_before;
		int mark;
		int ready_cnt;
		logic cs_seen;
		errs_before = err_cnt;
		ready_cnt = 0;
		cs_seen   = 1'b0;
		mark = mosi_q.size();
		run_op(ctrl_t'(`ADS_CTRL_SDATAC), '0, '0, '0);
		if (mosi_q.size() - mark != 1)
			report_mismatch("sdatac", "byte count", frame_t'(1), frame_t'(mosi_q.size() - mark));
		expect_mosi("sdatac", mark, 0, 8'h11);
		if (init_set !== 1'b0)
			report_mismatch("sdatac", "o_init_set", frame_t'(1'b0), frame_t'(init_set));
		if (ads_start !== 1'b0)
			report_mismatch("sdatac", "o_ads_start", frame_t'(1'b0), frame_t'(ads_start));
		@(posedge clk);
		ads_drdy_n <= 1'b0;
		repeat (FRAME_CYCLES) begin   // Long enough for a whole frame
			@(negedge clk);
			if (data_ready === 1'b1)
				ready_cnt++;
			cs_seen |= (spi_cs_n !== 1'b1);
		end
		@(posedge clk);
		ads_drdy_n <= 1'b1;
		if (ready_cnt != 0)
			report_mismatch("sdatac", "o_data_ready pulses", frame_t'(0), frame_t'(ready_cnt));
		if (cs_seen)
			note_failure("sdatac", "chip select fell after the stream was stopped");
		finish_test("sdatac", errs_before);
	endtask

	// ======================================================================
	// Run control
	// ======================================================================
	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		void'($urandom(32'h713f));
		arst_n     = 1'b0;
		control    = ctrl_t'(`ADS_CTRL_NONE);
		command    = '0;
		reg_addr   = '0;
		data_in    = '0;
		ads_drdy_n = 1'b1;   // DRDY idles high
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		check_power_up();
		send_command();
		write_register();
		read_register();
		stream_frames();
		stop_stream();
		$display("Tests run %0d, passed %0d, failed %0d, mismatches %0d",
			tests_run, tests_passed, tests_run - tests_passed, err_cnt);
		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/ads1292_assertions.sv
`default_nettype none

module ads1292_assertions (
	input wire i_clk,
	input wire i_arst_n,
	input wire i_spi_clk,
	input wire i_spi_cs_n,
	input wire i_data_ready,
	input wire i_init_set,
	input wire i_ads_start
);

	// ======================================================================
	// Pin protocol of the sensor top
	// ======================================================================
	// Mode 1 SCLK idles low outside a transfer
	a_sclk_idle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_spi_cs_n |-> !i_spi_clk)
		else $error("SCLK high while chip select is released");

	a_ready_pulse: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_data_ready |=> !i_data_ready)   // One clock per frame
		else $error("Data ready held longer than one cycle");

	// Conversions only run in continuous mode
	a_start_mode: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_ads_start |-> i_init_set)
		else $error("START pin high outside continuous mode");

endmodule

bind ads1292_sensor_top ads1292_assertions u_assertions (
	.i_clk        (i_clk),
	.i_arst_n     (i_arst_n),
	.i_spi_clk    (o_spi_clk),
	.i_spi_cs_n   (o_spi_cs_n),
	.i_data_ready (o_data_ready),
	.i_init_set   (o_init_set),
	.i_ads_start  (o_ads_start)
);

`default_nettype wire

// File: logic/ads1292_sensor_top.sv
`default_nettype none

module ads1292_sensor_top import ads1292_pkg::*; (
	input  wire    i_clk,
	input  wire    i_arst_n,
	// Host side
	input  wire ctrl_t i_control,
	input  wire byte_t i_command,
	input  wire byte_t i_reg_addr,
	input  wire byte_t i_data_in,
	output frame_t o_data_out,
	output byte_t  o_reg_data,
	output logic   o_data_ready,   // One cycle per frame
	output logic   o_init_set,     // Continuous mode running
	output logic   o_busy,
	// ADS1292 SPI
	output logic   o_spi_clk,
	input  wire    i_spi_miso,
	output logic   o_spi_mosi,
	output logic   o_spi_cs_n,
	// ADS1292 control pins
	input  wire    i_ads_drdy_n,
	output logic   o_ads_reset_n,
	output logic   o_ads_start
);

	// ======================================================================
	// Internal connections
	// ======================================================================
	logic  xfer_start;
	logic  xfer_frame;
	logic  xfer_done;
	logic  wait_start;
	logic  wait_sel;
	logic  wait_done;
	logic  load;
	byte_t tx_byte;
	logic  reg_strobe;
	logic  rise;
	logic  fall;

	ads1292_fsm u_fsm (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_control     (i_control),
		.i_command     (i_command),
		.i_reg_addr    (i_reg_addr),
		.i_data_in     (i_data_in),
		.i_ads_drdy_n  (i_ads_drdy_n),   // Synchronized inside
		.i_xfer_done   (xfer_done),
		.i_wait_done   (wait_done),
		.o_xfer_start  (xfer_start),
		.o_xfer_frame  (xfer_frame),
		.o_wait_start  (wait_start),
		.o_wait_sel    (wait_sel),
		.o_load        (load),
		.o_tx_byte     (tx_byte),
		.o_reg_strobe  (reg_strobe),
		.o_data_ready  (o_data_ready),
		.o_busy        (o_busy),
		.o_init_set    (o_init_set),
		.o_spi_cs_n    (o_spi_cs_n),
		.o_ads_reset_n (o_ads_reset_n),
		.o_ads_start   (o_ads_start)
	);

	spi_timing u_timing (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_xfer_start (xfer_start),
		.i_xfer_frame (xfer_frame),
		.i_wait_start (wait_start),
		.i_wait_sel   (wait_sel),
		.o_spi_clk    (o_spi_clk),
		.o_rise       (rise),
		.o_fall       (fall),
		.o_xfer_done  (xfer_done),
		.o_wait_done  (wait_done)
	);

	spi_shift_reg u_shift (
		.i_clk          (i_clk),
		.i_arst_n       (i_arst_n),
		.i_load         (load),
		.i_tx_byte      (tx_byte),
		.i_rise         (rise),
		.i_fall         (fall),
		.i_spi_miso     (i_spi_miso),
		.o_spi_mosi     (o_spi_mosi),
		.i_reg_strobe   (reg_strobe),
		.i_frame_strobe (o_data_ready),   // Frame copy rides on the ready pulse
		.o_data_out     (o_data_out),
		.o_reg_data     (o_reg_data)
	);

endmodule

`default_nettype wire

// File: logic/ads1292_fsm.sv
`default_nettype none

`include "ads1292_defines.svh"

module ads1292_fsm import ads1292_pkg::*; (
	input  wire   i_clk,
	input  wire   i_arst_n,
	// Host levels
	input  wire ctrl_t i_control,
	input  wire byte_t i_command,
	input  wire byte_t i_reg_addr,
	input  wire byte_t i_data_in,
	// Chip data ready, asynchronous
	input  wire   i_ads_drdy_n,
	// Timing unit
	input  wire   i_xfer_done,
	input  wire   i_wait_done,
	output logic  o_xfer_start,
	output logic  o_xfer_frame,   // 72-bit frame instead of one byte
	output logic  o_wait_start,
	output logic  o_wait_sel,     // 0 reset pulse, 1 wake wait
	// Shift register
	output logic  o_load,
	output byte_t o_tx_byte,
	output logic  o_reg_strobe,
	output logic  o_data_ready,   // Also the frame copy strobe
	// Status and pins
	output logic  o_busy,
	output logic  o_init_set,
	output logic  o_spi_cs_n,
	output logic  o_ads_reset_n,
	output logic  o_ads_start
);

	typedef enum logic [2:0] {
		S_POR,
		S_RST_WAIT,
		S_WAKE_WAIT,
		S_IDLE,
		S_XFER,
		S_RELEASE,
		S_FRAME
	} state_t;

	state_t     state;
	ctrl_t      op_q;        // Operation in flight
	byte_t      data_q;      // WREG payload
	logic [1:0] byte_idx;    // Byte within the operation
	logic [1:0] last_idx;
	logic       stream_q;    // RDATAC mode
	logic       drdy_s1;
	logic       drdy_s2;
	logic       drdy_d;
	logic       drdy_fall;
	logic       accept;
	logic       op_known;
	byte_t      first_byte;
	byte_t      next_byte;

	// ======================================================================
	// Decode
	// ======================================================================
	assign drdy_fall = drdy_d && !drdy_s2;

	// Only SDATAC is taken in continuous mode, so a held RDATAC never repeats
	assign accept = (i_control != ctrl_t'(`ADS_CTRL_NONE)) &&
		(!stream_q || i_control == ctrl_t'(`ADS_CTRL_SDATAC));

	always_comb begin
		op_known = 1'b1;
		case (i_control)
			ctrl_t'(`ADS_CTRL_CMD):    first_byte = i_command;
			ctrl_t'(`ADS_CTRL_WREG):   first_byte = byte_t'(`ADS_OP_WREG) | i_reg_addr;
			ctrl_t'(`ADS_CTRL_RREG):   first_byte = byte_t'(`ADS_OP_RREG) | i_reg_addr;
			ctrl_t'(`ADS_CTRL_RDATAC): first_byte = byte_t'(`ADS_OP_RDATAC);
			ctrl_t'(`ADS_CTRL_SDATAC): first_byte = byte_t'(`ADS_OP_SDATAC);
			default: begin
				first_byte = '0;
				op_known   = 1'b0;   // Unused code, no transfer
			end
		endcase
	end

	// Register access is opcode, count byte, data byte
	assign last_idx = (op_q == ctrl_t'(`ADS_CTRL_WREG) || op_q == ctrl_t'(`ADS_CTRL_RREG)) ?
		2'd2 : 2'd0;

	// Count byte is zero, third byte carries WREG data or dummy zeros for RREG
	assign next_byte = (byte_idx == 2'd1 && op_q == ctrl_t'(`ADS_CTRL_WREG)) ? data_q : '0;

	assign o_init_set  = stream_q;
	assign o_ads_start = stream_q;   // Conversions run only in continuous mode

	// ======================================================================
	// Sequencer
	// ======================================================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state         <= S_POR;
			op_q          <= ctrl_t'(`ADS_CTRL_NONE);
			data_q        <= '0;
			byte_idx      <= '0;
			stream_q      <= 1'b0;
			drdy_s1       <= 1'b1;   // DRDY idles high
			drdy_s2       <= 1'b1;
			drdy_d        <= 1'b1;
			o_xfer_start  <= 1'b0;
			o_xfer_frame  <= 1'b0;
			o_wait_start  <= 1'b0;
			o_wait_sel    <= 1'b0;
			o_load        <= 1'b0;
			o_tx_byte     <= '0;
			o_reg_strobe  <= 1'b0;
			o_data_ready  <= 1'b0;
			o_busy        <= 1'b1;   // Busy through power-up
			o_spi_cs_n    <= 1'b1;
			o_ads_reset_n <= 1'b0;   // Chip held in reset
		end else begin
			drdy_s1 <= i_ads_drdy_n;
			drdy_s2 <= drdy_s1;
			drdy_d  <= drdy_s2;
			// One-cycle pulses
			o_xfer_start <= 1'b0;
			o_wait_start <= 1'b0;
			o_load       <= 1'b0;
			o_reg_strobe <= 1'b0;
			o_data_ready <= 1'b0;
			case (state)
				S_POR: begin
					o_wait_start <= 1'b1;
					o_wait_sel   <= 1'b0;
					state        <= S_RST_WAIT;
				end
				S_RST_WAIT: if (i_wait_done) begin
					o_ads_reset_n <= 1'b1;
					o_wait_start  <= 1'b1;
					o_wait_sel    <= 1'b1;
					state         <= S_WAKE_WAIT;
				end
				S_WAKE_WAIT: if (i_wait_done) begin
					o_busy <= 1'b0;
					state  <= S_IDLE;
				end
				S_IDLE: begin
					if (accept) begin
						o_busy   <= 1'b1;
						op_q     <= i_control;
						data_q   <= i_data_in;
						byte_idx <= '0;
						if (op_known) begin
							o_spi_cs_n   <= 1'b0;
							o_load       <= 1'b1;
							o_tx_byte    <= first_byte;
							o_xfer_start <= 1'b1;
							o_xfer_frame <= 1'b0;
							state        <= S_XFER;
						end else begin
							state <= S_RELEASE;
						end
					end else if (stream_q && drdy_fall &&
						i_control == ctrl_t'(`ADS_CTRL_NONE)) begin
						o_busy       <= 1'b1;    // Blocks the host for the frame
						o_spi_cs_n   <= 1'b0;
						o_load       <= 1'b1;
						o_tx_byte    <= '0;      // MOSI low while reading data
						o_xfer_start <= 1'b1;
						o_xfer_frame <= 1'b1;
						state        <= S_FRAME;
					end
				end
				S_XFER: if (i_xfer_done) begin
					if (byte_idx == last_idx) begin
						o_spi_cs_n   <= 1'b1;
						o_reg_strobe <= (op_q == ctrl_t'(`ADS_CTRL_RREG));
						if (op_q == ctrl_t'(`ADS_CTRL_RDATAC)) begin
							stream_q <= 1'b1;
							o_busy   <= 1'b0;   // No wait for release here
							state    <= S_IDLE;
						end else begin
							if (op_q == ctrl_t'(`ADS_CTRL_SDATAC))
								stream_q <= 1'b0;
							state <= S_RELEASE;
						end
					end else begin
						byte_idx     <= byte_idx + 2'd1;   // CS stays low
						o_load       <= 1'b1;
						o_tx_byte    <= next_byte;
						o_xfer_start <= 1'b1;
					end
				end
				S_RELEASE: if (i_control == ctrl_t'(`ADS_CTRL_NONE)) begin
					o_busy <= 1'b0;
					state  <= S_IDLE;
				end
				S_FRAME: if (i_xfer_done) begin
					o_spi_cs_n   <= 1'b1;
					o_data_ready <= 1'b1;
					o_busy       <= 1'b0;
					state        <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/spi_shift_reg.sv
`default_nettype none

`include "ads1292_defines.svh"

module spi_shift_reg import ads1292_pkg::*; (
	input  wire    i_clk,
	input  wire    i_arst_n,
	// Transmit side
	input  wire    i_load,
	input  wire byte_t i_tx_byte,
	// Edge pulses from the timing unit
	input  wire    i_rise,
	input  wire    i_fall,
	// SPI pins
	input  wire    i_spi_miso,
	output logic   o_spi_mosi,
	// Capture strobes
	input  wire    i_reg_strobe,
	input  wire    i_frame_strobe,
	output frame_t o_data_out,
	output byte_t  o_reg_data
);

	byte_t  tx_sr;    // Next bits to send, MSB first
	frame_t rx_sr;    // MISO bits, newest in bit 0
	frame_t data_q;   // Last captured frame

	// ======================================================================
	// MOSI
	// ======================================================================
	// Pin changes together with the rising SCLK edge
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_spi_mosi <= 1'b0;
		else if (i_rise)
			o_spi_mosi <= tx_sr[`ADS_BYTE_W-1];
	end

	always_ff @(posedge i_clk) begin
		if (i_load)
			tx_sr <= i_tx_byte;
		else if (i_rise)
			tx_sr <= {tx_sr[`ADS_BYTE_W-2:0], 1'b0};   // Zeros follow the byte
	end

	// ======================================================================
	// MISO
	// ======================================================================
	// Sampled on the cycle SCLK falls
	always_ff @(posedge i_clk) begin
		if (i_fall)
			rx_sr <= {rx_sr[`ADS_FRAME_W-2:0], i_spi_miso};
	end

	// Read byte is the last one shifted in
	always_ff @(posedge i_clk) begin
		if (i_reg_strobe)
			o_reg_data <= rx_sr[`ADS_BYTE_W-1:0];
	end

	always_ff @(posedge i_clk) begin
		if (i_frame_strobe)
			data_q <= rx_sr;
	end

	// Fresh frame visible in the strobe cycle itself
	// rx_sr holds still until the next transfer starts
	assign o_data_out = i_frame_strobe ? rx_sr : data_q;

endmodule

`default_nettype wire

// File: logic/spi_timing.sv
`default_nettype none

`include "ads1292_defines.svh"

module spi_timing import ads1292_pkg::*; (
	input  wire  i_clk,
	input  wire  i_arst_n,
	input  wire  i_xfer_start,
	input  wire  i_xfer_frame,   // 72 bits, else 8
	input  wire  i_wait_start,
	input  wire  i_wait_sel,     // 0 reset pulse, 1 wake wait
	output logic o_spi_clk,
	output logic o_rise,         // SCLK rises on the next edge
	output logic o_fall,         // SCLK falls on the next edge
	output logic o_xfer_done,
	output logic o_wait_done
);

	logic       xfer_active;
	logic       trail;         // Last fall done, CS tail half running
	logic [7:0] half_cnt;
	bit_cnt_t   bits_left;
	logic       sclk_q;
	logic       half_tick;
	logic       wait_active;
	logic [7:0] wait_cnt;

	// ======================================================================
	// SCLK generation
	// ======================================================================
	assign half_tick   = xfer_active && (half_cnt == 8'(`ADS_SCLK_HALF - 1));
	assign o_rise      = half_tick && !trail && !sclk_q;
	assign o_fall      = half_tick && !trail && sclk_q;
	assign o_xfer_done = half_tick && trail;
	assign o_spi_clk   = sclk_q;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			xfer_active <= 1'b0;
			trail       <= 1'b0;
			half_cnt    <= '0;
			bits_left   <= '0;
			sclk_q      <= 1'b0;   // Mode 1 idles low
		end else if (i_xfer_start) begin
			xfer_active <= 1'b1;
			trail       <= 1'b0;
			half_cnt    <= 8'd1;   // Start request cycle counts toward the lead half
			bits_left   <= i_xfer_frame ? bit_cnt_t'(`ADS_FRAME_W) : bit_cnt_t'(`ADS_BYTE_W);
			sclk_q      <= 1'b0;
		end else if (xfer_active) begin
			if (half_tick) begin
				half_cnt <= '0;
				if (trail) begin
					xfer_active <= 1'b0;
				end else begin
					sclk_q <= ~sclk_q;
					if (sclk_q) begin   // Falling edge ends a bit
						bits_left <= bits_left - bit_cnt_t'(1);
						if (bits_left == bit_cnt_t'(1))
							trail <= 1'b1;
					end
				end
			end else begin
				half_cnt <= half_cnt + 8'd1;
			end
		end
	end

	// ======================================================================
	// Power-up waits
	// ======================================================================
	// Load is two short for the request and response cycles in the FSM
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wait_active <= 1'b0;
			wait_cnt    <= '0;
		end else if (i_wait_start) begin
			wait_active <= 1'b1;
			wait_cnt    <= i_wait_sel ? 8'(`ADS_WAKE_CYCLES - 2) : 8'(`ADS_RESET_CYCLES - 2);
		end else if (wait_active) begin
			if (wait_cnt == '0)
				wait_active <= 1'b0;
			else
				wait_cnt <= wait_cnt - 8'd1;
		end
	end

	assign o_wait_done = wait_active && (wait_cnt == '0);

endmodule

`default_nettype wire

// File: logic/ads1292_pkg.sv
`default_nettype none

`include "ads1292_defines.svh"

// ==========================================================================
// Shared types of the ADS1292 controller
// ==========================================================================
package ads1292_pkg;

	// One SPI byte on MOSI or MISO
	typedef logic [`ADS_BYTE_W-1:0] byte_t;

	// Continuous mode frame
	// Status word in the top 24 bits, then channel 1, then channel 2
	typedef logic [`ADS_FRAME_W-1:0] frame_t;

	// Host operation select
	typedef logic [`ADS_CTRL_W-1:0] ctrl_t;

	// SCLK bits left in a transfer
	typedef logic [`ADS_BIT_CNT_W-1:0] bit_cnt_t;

endpackage

`default_nettype wire

// File: logic/ads1292_defines.svh
`ifndef ADS1292_DEFINES_SVH
`define ADS1292_DEFINES_SVH

// ==========================================================================
// Widths
// ==========================================================================
`define ADS_BYTE_W          8
`define ADS_FRAME_W         72    // 24 status bits and two 24-bit channels
`define ADS_CTRL_W          3
`define ADS_BIT_CNT_W       7     // Holds a full frame count

// Timing in i_clk cycles
`define ADS_SCLK_HALF       4
`define ADS_RESET_CYCLES    16    // Reset pin low pulse
`define ADS_WAKE_CYCLES     32    // Chip wake after reset release

// Host control codes
`define ADS_CTRL_NONE       3'd0
`define ADS_CTRL_CMD        3'd1
`define ADS_CTRL_WREG       3'd2
`define ADS_CTRL_RREG       3'd3
`define ADS_CTRL_RDATAC     3'd4
`define ADS_CTRL_SDATAC     3'd5

// SPI opcodes. Register address goes into the low bits of WREG and RREG
`define ADS_OP_WREG         8'h40
`define ADS_OP_RREG         8'h20
`define ADS_OP_RDATAC       8'h10
`define ADS_OP_SDATAC       8'h11

`endif
